/* include/m107_consts.svh */
// Arcade glue constants for bus widths, DIP download slot and native aspect ratio

`ifndef M107_CONSTS_SVH
`define M107_CONSTS_SVH

//////////////////////////////////////////////////
// Control words
//////////////////////////////////////////////////

// One joystick or keyboard word from the host
`define M107_JOY_W 16

// Control bits per player as seen by the core
`define M107_PLAYER_W 10

//////////////////////////////////////////////////
// Memory buses
//////////////////////////////////////////////////

// SDRAM byte address
`define M107_SDR_ADDR_W 25

// DDRAM 64-bit word address
`define M107_DDR_ADDR_W 29

//////////////////////////////////////////////////
// DIP switches
//////////////////////////////////////////////////

`define M107_DIP_INDEX 254
`define M107_DIP_BYTES 8
// Only the low bytes reach the core
`define M107_DIP_OUT_BYTES 3

//////////////////////////////////////////////////
// Aspect ratio
//////////////////////////////////////////////////

`define M107_ASPECT_W 12
`define M107_ASPECT_LONG 4
`define M107_ASPECT_SHORT 3

`endif

/* hw/m107_io_pkg.sv */
// Player control and DIP switch types shared by the input side of the glue

`default_nettype none

`include "m107_consts.svh"

package m107_io_pkg;

    //////////////////////////////////////////////////
    // Raw controls
    //////////////////////////////////////////////////

    // Joystick or keyboard word, one bit per button or direction
    typedef logic [`M107_JOY_W-1:0] joy_word_t;

    // Buttons and directions forwarded to the core for one player
    typedef logic [`M107_PLAYER_W-1:0] player_bits_t;

    // One flag per player, bit 0 is player 1
    typedef logic [3:0] player_set_t;

    // DIP switch byte, a cleared bit is a switch turned on
    typedef logic [7:0] dip_byte_t;

    //////////////////////////////////////////////////
    // Mapped inputs
    //////////////////////////////////////////////////

    // Everything the core samples from the players
    typedef struct packed {
        player_bits_t p1;
        player_bits_t p2;
        player_bits_t p3;
        player_bits_t p4;
        // Start buttons, players 4 down to 1
        player_set_t  start;
        // Only coin slot 1 is ever raised
        player_set_t  coin;
        logic         pause;
    } mapped_inputs_t;

endpackage

`default_nettype wire

/* hw/m107_mem_pkg.sv */
// SDRAM and DDRAM request types for the shared memory ports

`default_nettype none

`include "m107_consts.svh"

package m107_mem_pkg;

    //////////////////////////////////////////////////
    // SDRAM
    //////////////////////////////////////////////////

    typedef logic [`M107_SDR_ADDR_W-1:0] sdr_addr_t;
    typedef logic [15:0]                 sdr_word_t;
    typedef logic [1:0]                  sdr_be_t;

    // Write from the ROM loader
    typedef struct packed {
        sdr_addr_t addr;
        sdr_word_t data;
        sdr_be_t   be;
        logic      req;
    } rom_sdr_req_t;

    // Read from the running system
    typedef struct packed {
        sdr_addr_t addr;
        logic      req;
    } cpu_sdr_req_t;

    // Request into controller channel 3
    typedef struct packed {
        sdr_addr_t addr;
        sdr_word_t din;
        sdr_be_t   be;
        // High for a read
        logic      rnw;
        logic      req;
    } sdr_ch3_t;

    //////////////////////////////////////////////////
    // DDRAM
    //////////////////////////////////////////////////

    typedef logic [`M107_DDR_ADDR_W-1:0] ddr_addr_t;
    typedef logic [7:0]                  ddr_be_t;

    // Avalon style command toward the DDR3 bridge
    typedef struct packed {
        logic [7:0] burstcnt;
        ddr_addr_t  addr;
        logic       rd;
        ddr_be_t    be;
        logic       we;
    } ddr_cmd_t;

endpackage

`default_nettype wire

/* hw/dip_switch_capture.sv */
// DIP switch bank loaded from the download stream and forwarded to the core

`default_nettype none

`include "m107_consts.svh"

module dip_switch_capture (
    input  logic                              clk_sys,
    input  logic                              rst_n,
    input  logic                              dl_wr,
    input  logic [7:0]                        dl_index,
    input  m107_mem_pkg::sdr_addr_t           dl_addr,
    input  m107_io_pkg::dip_byte_t            dl_data,
    output logic [`M107_DIP_OUT_BYTES*8-1:0]  dip_out
);

    import m107_io_pkg::*;
    import m107_mem_pkg::*;

    localparam int slot_w = $clog2(`M107_DIP_BYTES);

    dip_byte_t dip_sw [`M107_DIP_BYTES];
    logic      dip_hit;

    // Only the first eight addresses of the DIP index land in the bank
    assign dip_hit = dl_wr
                  && (dl_index == 8'(`M107_DIP_INDEX))
                  && (dl_addr[`M107_SDR_ADDR_W-1:slot_w] == '0);

    // Switches start released, which reads as all ones
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `M107_DIP_BYTES; i++) begin
                dip_sw[i] <= '1;
            end
        end else if (dip_hit) begin
            dip_sw[dl_addr[slot_w-1:0]] <= dl_data;
        end
    end

    // Byte 0 sits in the low lane
    always_comb begin
        for (int i = 0; i < `M107_DIP_OUT_BYTES; i++) begin
            dip_out[i*8 +: 8] = dip_sw[i];
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // A floating strobe would corrupt the bank at random
    a_dl_wr_known: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        !$isunknown(dl_wr)
    );

endmodule

`default_nettype wire

/* hw/player_input_mapper.sv */
// Keyboard and joystick merge into per-player controls with start, coin and pause

`default_nettype none

`include "m107_consts.svh"

module player_input_mapper (
    input  logic                         clk_sys,
    input  logic                         rst_n,
    input  m107_io_pkg::joy_word_t       joy_p1,
    input  m107_io_pkg::joy_word_t       joy_p2,
    input  m107_io_pkg::joy_word_t       joy_p3,
    input  m107_io_pkg::joy_word_t       joy_p4,
    input  m107_io_pkg::joy_word_t       kbd_p1,
    input  m107_io_pkg::joy_word_t       kbd_p2,
    input  m107_io_pkg::joy_word_t       kbd_p3,
    input  m107_io_pkg::joy_word_t       kbd_p4,
    input  m107_io_pkg::player_set_t     key_start,
    input  m107_io_pkg::player_set_t     key_coin,
    input  logic                         key_pause,
    output m107_io_pkg::mapped_inputs_t  mapped
);

    import m107_io_pkg::*;

    // Host joystick button positions
    localparam int btn_start = 10;
    localparam int btn_coin  = 11;
    localparam int btn_start2 = 12;
    localparam int btn_pause = 13;

    joy_word_t      merged_p1;
    joy_word_t      merged_p2;
    joy_word_t      merged_p3;
    joy_word_t      merged_p4;
    joy_word_t      joy_any;
    mapped_inputs_t mapped_next;

    assign merged_p1 = kbd_p1 | joy_p1;
    assign merged_p2 = kbd_p2 | joy_p2;
    assign merged_p3 = kbd_p3 | joy_p3;
    assign merged_p4 = kbd_p4 | joy_p4;

    // Shared buttons may come from any pad
    assign joy_any = joy_p1 | joy_p2 | joy_p3 | joy_p4;

    //////////////////////////////////////////////////
    // Mapping
    //////////////////////////////////////////////////

    always_comb begin
        mapped_next.p1 = merged_p1[`M107_PLAYER_W-1:0];
        mapped_next.p2 = merged_p2[`M107_PLAYER_W-1:0];
        mapped_next.p3 = merged_p3[`M107_PLAYER_W-1:0];
        mapped_next.p4 = merged_p4[`M107_PLAYER_W-1:0];

        mapped_next.start[0] = joy_p1[btn_start] | key_start[0];
        // Player 2 start also answers the extra start button on any pad
        mapped_next.start[1] = joy_p2[btn_start] | joy_any[btn_start2] | key_start[1];
        mapped_next.start[2] = joy_p3[btn_start] | key_start[2];
        mapped_next.start[3] = joy_p4[btn_start] | key_start[3];

        // All coins go into slot 1
        mapped_next.coin    = '0;
        mapped_next.coin[0] = joy_any[btn_coin] | (|key_coin);

        mapped_next.pause = joy_any[btn_pause] | key_pause;
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            mapped <= '0;
        end else begin
            mapped <= mapped_next;
        end
    end

endmodule

`default_nettype wire

/* hw/rom_load_port_mux.sv */
// Hands SDRAM channel 3 and DDRAM to the ROM loader during a load, else to the system

`default_nettype none

module rom_load_port_mux (
    input  logic                        clk_sys,
    input  logic                        rst_n,
    input  logic                        rom_load_busy,
    input  m107_mem_pkg::rom_sdr_req_t  rom_sdr,
    input  m107_mem_pkg::cpu_sdr_req_t  cpu_sdr,
    output m107_mem_pkg::sdr_ch3_t      ch3,
    input  m107_mem_pkg::ddr_cmd_t      ddr_rom,
    input  m107_mem_pkg::ddr_cmd_t      ddr_rot,
    output m107_mem_pkg::ddr_cmd_t      ddr_out
);

    import m107_mem_pkg::*;

    //////////////////////////////////////////////////
    // SDRAM channel 3
    //////////////////////////////////////////////////

    always_comb begin
        // Write data only matters during a load
        ch3.din = rom_sdr.data;
        if (rom_load_busy) begin
            ch3.addr = rom_sdr.addr;
            ch3.be   = rom_sdr.be;
            ch3.rnw  = 1'b0;
            ch3.req  = rom_sdr.req;
        end else begin
            ch3.addr = cpu_sdr.addr;
            ch3.be   = '0;
            ch3.rnw  = 1'b1;
            ch3.req  = cpu_sdr.req;
        end
    end

    //////////////////////////////////////////////////
    // DDRAM
    //////////////////////////////////////////////////

    // Loader owns DDRAM while busy, the rotation buffer otherwise
    always_comb begin
        if (rom_load_busy) begin
            ddr_out = ddr_rom;
        end else begin
            ddr_out = ddr_rot;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // The system only reads through channel 3
    a_cpu_read_only: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        !rom_load_busy |-> (ch3.rnw && (ch3.be == '0))
    );

    // The loader only writes
    a_rom_write_only: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        rom_load_busy |-> !ch3.rnw
    );

endmodule

`default_nettype wire

/* hw/aspect_ratio_select.sv */
// Video aspect ratio from the menu mode and the screen orientation

`default_nettype none

`include "m107_consts.svh"

module aspect_ratio_select (
    input  logic                      clk_sys,
    input  logic                      rst_n,
    input  logic [1:0]                ar_mode,
    input  logic                      no_rotate,
    output logic [`M107_ASPECT_W-1:0] arx,
    output logic [`M107_ASPECT_W-1:0] ary
);

    localparam logic [`M107_ASPECT_W-1:0] ratio_long  = `M107_ASPECT_LONG;
    localparam logic [`M107_ASPECT_W-1:0] ratio_short = `M107_ASPECT_SHORT;

    // Scaler preset index for the non-native modes
    logic [1:0] preset;

    assign preset = ar_mode - 2'd1;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            arx <= '0;
            ary <= '0;
        end else if (ar_mode == 2'd0) begin
            // Native ratio, turned on its side for a vertical screen
            arx <= no_rotate ? ratio_long : ratio_short;
            ary <= no_rotate ? ratio_short : ratio_long;
        end else begin
            // ary of zero tells the scaler to use a preset
            arx <= {{(`M107_ASPECT_W-2){1'b0}}, preset};
            ary <= '0;
        end
    end

endmodule

`default_nettype wire

/* hw/arcade_glue_top.sv */
// Board glue top with DIP capture, input mapping, memory port selection and aspect

`default_nettype none

`include "m107_consts.svh"

module arcade_glue_top (
    input  logic                              clk_sys,
    input  logic                              rst_n,

    // Download port
    input  logic                              dl_wr,
    input  logic [7:0]                        dl_index,
    input  m107_mem_pkg::sdr_addr_t           dl_addr,
    input  m107_io_pkg::dip_byte_t            dl_data,
    output logic [`M107_DIP_OUT_BYTES*8-1:0]  dip_out,

    // Player controls
    input  m107_io_pkg::joy_word_t            joy_p1,
    input  m107_io_pkg::joy_word_t            joy_p2,
    input  m107_io_pkg::joy_word_t            joy_p3,
    input  m107_io_pkg::joy_word_t            joy_p4,
    input  m107_io_pkg::joy_word_t            kbd_p1,
    input  m107_io_pkg::joy_word_t            kbd_p2,
    input  m107_io_pkg::joy_word_t            kbd_p3,
    input  m107_io_pkg::joy_word_t            kbd_p4,
    input  m107_io_pkg::player_set_t          key_start,
    input  m107_io_pkg::player_set_t          key_coin,
    input  logic                              key_pause,
    output m107_io_pkg::mapped_inputs_t       mapped,

    // Shared memory ports
    input  logic                              rom_load_busy,
    input  m107_mem_pkg::rom_sdr_req_t        rom_sdr,
    input  m107_mem_pkg::cpu_sdr_req_t        cpu_sdr,
    output m107_mem_pkg::sdr_ch3_t            ch3,
    input  logic                              sdr_ch3_rdy,
    output logic                              cpu_rdy,
    output logic                              rom_rdy,
    input  m107_mem_pkg::ddr_cmd_t            ddr_rom,
    input  m107_mem_pkg::ddr_cmd_t            ddr_rot,
    output m107_mem_pkg::ddr_cmd_t            ddr_out,

    // Video
    input  logic [1:0]                        ar_mode,
    input  logic                              no_rotate,
    output logic [`M107_ASPECT_W-1:0]         arx,
    output logic [`M107_ASPECT_W-1:0]         ary
);

    //////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////

    dip_switch_capture u_dip (
        .clk_sys, .rst_n, .dl_wr, .dl_index, .dl_addr, .dl_data, .dip_out
    );

    player_input_mapper u_inputs (
        .clk_sys, .rst_n,
        .joy_p1, .joy_p2, .joy_p3, .joy_p4,
        .kbd_p1, .kbd_p2, .kbd_p3, .kbd_p4,
        .key_start, .key_coin, .key_pause, .mapped
    );

    //////////////////////////////////////////////////
    // Memory ports
    //////////////////////////////////////////////////

    rom_load_port_mux u_port_mux (
        .clk_sys, .rst_n, .rom_load_busy,
        .rom_sdr, .cpu_sdr, .ch3, .ddr_rom, .ddr_rot, .ddr_out
    );

    // One ready serves whichever side owns channel 3
    assign cpu_rdy = sdr_ch3_rdy;
    assign rom_rdy = sdr_ch3_rdy;

    //////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////

    aspect_ratio_select u_aspect (
        .clk_sys, .rst_n, .ar_mode, .no_rotate, .arx, .ary
    );

endmodule

`default_nettype wire

/* bench/arcade_glue_tb.sv */
// Testbench for the arcade board glue, table driven with LFSR filled player controls

`default_nettype none

`include "m107_consts.svh"

module arcade_glue_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import m107_io_pkg::*;
    import m107_mem_pkg::*;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 8;
    localparam int n_entries    = 19;

    localparam logic [1:0] op_dip = 2'd0;
    localparam logic [1:0] op_map = 2'd1;
    localparam logic [1:0] op_mux = 2'd2;
    localparam logic [1:0] op_asp = 2'd3;

    // Meaning of p0, p1 and p2 depends on op
    typedef struct packed {
        logic [1:0]  op;
        logic [7:0]  p0;
        logic [7:0]  p1;
        logic [7:0]  p2;
        logic [23:0] exp_val;
    } entry_t;

    logic                             clk_sys = 1'b0;
    logic                             rst_n;
    logic                             dl_wr;
    logic [7:0]                       dl_index;
    sdr_addr_t                        dl_addr;
    dip_byte_t                        dl_data;
    logic [`M107_DIP_OUT_BYTES*8-1:0] dip_out;
    joy_word_t                        joy_w [4];
    joy_word_t                        kbd_w [4];
    player_set_t                      key_start;
    player_set_t                      key_coin;
    logic                             key_pause;
    mapped_inputs_t                   mapped;
    logic                             rom_load_busy;
    rom_sdr_req_t                     rom_sdr;
    cpu_sdr_req_t                     cpu_sdr;
    sdr_ch3_t                         ch3;
    logic                             sdr_ch3_rdy;
    logic                             cpu_rdy;
    logic                             rom_rdy;
    ddr_cmd_t                         ddr_rom;
    ddr_cmd_t                         ddr_rot;
    ddr_cmd_t                         ddr_out;
    logic [1:0]                       ar_mode;
    logic                             no_rotate;
    logic [`M107_ASPECT_W-1:0]        arx;
    logic [`M107_ASPECT_W-1:0]        ary;

    entry_t      table_e [n_entries];
    logic [15:0] lfsr_state;

    arcade_glue_top dut (
        .clk_sys(clk_sys), .rst_n(rst_n),
        .dl_wr(dl_wr), .dl_index(dl_index), .dl_addr(dl_addr), .dl_data(dl_data),
        .dip_out(dip_out),
        .joy_p1(joy_w[0]), .joy_p2(joy_w[1]), .joy_p3(joy_w[2]), .joy_p4(joy_w[3]),
        .kbd_p1(kbd_w[0]), .kbd_p2(kbd_w[1]), .kbd_p3(kbd_w[2]), .kbd_p4(kbd_w[3]),
        .key_start(key_start), .key_coin(key_coin), .key_pause(key_pause),
        .mapped(mapped),
        .rom_load_busy(rom_load_busy), .rom_sdr(rom_sdr), .cpu_sdr(cpu_sdr), .ch3(ch3),
        .sdr_ch3_rdy(sdr_ch3_rdy), .cpu_rdy(cpu_rdy), .rom_rdy(rom_rdy),
        .ddr_rom(ddr_rom), .ddr_rot(ddr_rot), .ddr_out(ddr_out),
        .ar_mode(ar_mode), .no_rotate(no_rotate), .arx(arx), .ary(ary)
    );

    always #(clk_period / 2) clk_sys = ~clk_sys;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_random(input int nbits, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[62:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "%s differs from its expected value", name);
        end
    endtask

    // Player bits, start, coin and pause as the host mapping defines them
    function automatic mapped_inputs_t expect_mapped();
        mapped_inputs_t m;
        player_bits_t   bits [4];
        joy_word_t      both;
        m = '0;
        for (int n = 0; n < 4; n++) begin
            both       = kbd_w[n] | joy_w[n];
            bits[n]    = both[`M107_PLAYER_W-1:0];
            m.start[n] = m.start[n] | joy_w[n][10] | key_start[n];
            // Bit 12 of any pad is a second player 2 start
            m.start[1] = m.start[1] | joy_w[n][12];
            m.coin[0]  = m.coin[0] | joy_w[n][11];
            m.pause    = m.pause | joy_w[n][13];
        end
        m.coin[0] = m.coin[0] | (|key_coin);
        m.pause   = m.pause | key_pause;
        m.p1 = bits[0];
        m.p2 = bits[1];
        m.p3 = bits[2];
        m.p4 = bits[3];
        return m;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    task automatic load_table();
        // DIP writes: index, address, data, expected dip_out
        table_e[0]  = '{op_dip, 8'hfe, 8'h00, 8'h5a, 24'hffff5a};
        table_e[1]  = '{op_dip, 8'hfe, 8'h01, 8'h3c, 24'hff3c5a};
        table_e[2]  = '{op_dip, 8'hfe, 8'h02, 8'ha5, 24'ha53c5a};
        table_e[3]  = '{op_dip, 8'hfd, 8'h00, 8'h00, 24'ha53c5a};
        table_e[4]  = '{op_dip, 8'hfe, 8'h08, 8'h00, 24'ha53c5a};
        table_e[5]  = '{op_dip, 8'hfe, 8'h05, 8'h00, 24'ha53c5a};
        // Inputs: {start, coin} keys, pause key, clear pad buttons
        table_e[6]  = '{op_map, 8'h52, 8'h00, 8'h01, 24'h0};
        table_e[7]  = '{op_map, 8'h21, 8'h01, 8'h01, 24'h0};
        table_e[8]  = '{op_map, 8'h00, 8'h00, 8'h00, 24'h0};
        table_e[9]  = '{op_map, 8'h84, 8'h00, 8'h00, 24'h0};
        // Ports: busy, ready
        table_e[10] = '{op_mux, 8'h01, 8'h00, 8'h00, 24'h0};
        table_e[11] = '{op_mux, 8'h01, 8'h01, 8'h00, 24'h0};
        table_e[12] = '{op_mux, 8'h00, 8'h01, 8'h00, 24'h0};
        table_e[13] = '{op_mux, 8'h00, 8'h00, 8'h00, 24'h0};
        // Aspect: mode, no_rotate, expected {arx, ary}
        table_e[14] = '{op_asp, 8'h00, 8'h01, 8'h00, 24'h004003};
        table_e[15] = '{op_asp, 8'h00, 8'h00, 8'h00, 24'h003004};
        table_e[16] = '{op_asp, 8'h01, 8'h00, 8'h00, 24'h000000};
        table_e[17] = '{op_asp, 8'h02, 8'h01, 8'h00, 24'h001000};
        table_e[18] = '{op_asp, 8'h03, 8'h00, 8'h00, 24'h002000};
    endtask

    task automatic apply_entry(input entry_t e);
        logic [63:0]    r;
        sdr_ch3_t       exp_ch3;
        mapped_inputs_t exp_map;
        @(posedge clk_sys);
        #2;
        case (e.op)
            op_dip: begin
                dl_index = e.p0;
                dl_addr  = {{(`M107_SDR_ADDR_W-8){1'b0}}, e.p1};
                dl_data  = e.p2;
                dl_wr    = 1'b1;
                @(posedge clk_sys);
                #2;
                dl_wr = 1'b0;
                check_value("dip_out", 64'(dip_out), 64'(e.exp_val));
            end
            op_map: begin
                for (int n = 0; n < 4; n++) begin
                    take_random(16, r);
                    joy_w[n] = r[15:0];
                    take_random(16, r);
                    kbd_w[n] = r[15:0];
                    if (e.p2[0]) begin
                        joy_w[n][15:10] = '0;
                    end
                end
                key_start = e.p0[7:4];
                key_coin  = e.p0[3:0];
                key_pause = e.p1[0];
                exp_map   = expect_mapped();
                @(posedge clk_sys);
                #2;
                check_value("mapped", 64'(mapped), 64'(exp_map));
            end
            op_mux: begin
                take_random($bits(rom_sdr_req_t), r);
                rom_sdr = r[$bits(rom_sdr_req_t)-1:0];
                take_random($bits(cpu_sdr_req_t), r);
                cpu_sdr = r[$bits(cpu_sdr_req_t)-1:0];
                take_random($bits(ddr_cmd_t), r);
                ddr_rom = r[$bits(ddr_cmd_t)-1:0];
                take_random($bits(ddr_cmd_t), r);
                ddr_rot = r[$bits(ddr_cmd_t)-1:0];
                rom_load_busy = e.p0[0];
                sdr_ch3_rdy   = e.p1[0];
                // Loader writes while busy, the system reads otherwise
                exp_ch3.din  = rom_sdr.data;
                exp_ch3.addr = rom_load_busy ? rom_sdr.addr : cpu_sdr.addr;
                exp_ch3.be   = rom_load_busy ? rom_sdr.be : 2'b00;
                exp_ch3.rnw  = !rom_load_busy;
                exp_ch3.req  = rom_load_busy ? rom_sdr.req : cpu_sdr.req;
                #1;
                check_value("ch3", 64'(ch3), 64'(exp_ch3));
                check_value("ddr_out", 64'(ddr_out), 64'(rom_load_busy ? ddr_rom : ddr_rot));
                check_value("cpu_rdy", 64'(cpu_rdy), 64'(sdr_ch3_rdy));
                check_value("rom_rdy", 64'(rom_rdy), 64'(sdr_ch3_rdy));
            end
            default: begin
                ar_mode   = e.p0[1:0];
                no_rotate = e.p1[0];
                @(posedge clk_sys);
                #2;
                check_value("arx", 64'(arx), 64'(e.exp_val[23:12]));
                check_value("ary", 64'(ary), 64'(e.exp_val[11:0]));
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        lfsr_state    = 16'd70;
        rst_n         = 1'b0;
        dl_wr         = 1'b0;
        dl_index      = '0;
        dl_addr       = '0;
        dl_data       = '0;
        key_start     = '0;
        key_coin      = '0;
        key_pause     = 1'b0;
        rom_load_busy = 1'b0;
        rom_sdr       = '0;
        cpu_sdr       = '0;
        sdr_ch3_rdy   = 1'b0;
        ddr_rom       = '0;
        ddr_rot       = '0;
        ar_mode       = '0;
        no_rotate     = 1'b0;
        for (int n = 0; n < 4; n++) begin
            joy_w[n] = '0;
            kbd_w[n] = '0;
        end
        load_table();
        repeat (reset_cycles - 1) @(posedge clk_sys);
        #2;
        // Sampled while reset still holds the registers
        check_value("dip_out", 64'(dip_out), 64'hff_ffff);
        check_value("mapped", 64'(mapped), 64'h0);
        check_value("arx", 64'(arx), 64'h0);
        check_value("ary", 64'(ary), 64'h0);
        @(posedge clk_sys);
        #2;
        rst_n = 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            apply_entry(table_e[i]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Each entry needs at most two cycles
    initial begin
        #((n_entries * 4 + reset_cycles) * clk_period);
        $display("Timeout: the stimulus table did not finish in the allowed time");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
hw/m107_io_pkg.sv
hw/m107_mem_pkg.sv
hw/dip_switch_capture.sv
hw/player_input_mapper.sv
hw/rom_load_port_mux.sv
hw/aspect_ratio_select.sv
hw/arcade_glue_top.sv
bench/arcade_glue_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the arcade glue testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator is not on the PATH"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f all.f --top-module arcade_glue_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Varcade_glue_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi
exit 0
